// ==== sources.f ====
+incdir+sim
rtl/mem_pkg.sv
rtl/mem_req_if.sv
rtl/ram_rsp_if.sv
rtl/store_align.sv
rtl/data_ram.sv
rtl/load_extract.sv
rtl/mem_stage.sv
sim/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # Design, in compile order
  - rtl/mem_pkg.sv
  - rtl/mem_req_if.sv
  - rtl/ram_rsp_if.sv
  - rtl/store_align.sv
  - rtl/data_ram.sv
  - rtl/load_extract.sv
  - rtl/mem_stage.sv

  # Testbench with its reference model header
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mem_stage.sv

// ==== sim/mem_ref_model.svh ====
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Reference memory, one entry per word, indexed from byte addresses below
logic [DATA_W-1:0] ref_mem [RAM_WORDS];

function automatic void clear_model();
    for (int i = 0; i < RAM_WORDS; i++)
        ref_mem[i] = '0;
endfunction

// Bytes touched by one access
function automatic int access_size(input mem_op_e op);
    case (op)
        op_word:              return 4;
        op_half_u, op_half_s: return 2;
        default:              return 1;
    endcase
endfunction

// An access must start on a multiple of its own size
function automatic bit is_misaligned(input mem_op_e op, input logic [31:0] a);
    return (a % access_size(op)) != 0;
endfunction

// Upper address bits fold back onto the array
function automatic int word_index(input logic [31:0] a);
    return (a / 4) % RAM_WORDS;
endfunction

function automatic void apply_store(input mem_op_e op, input logic [31:0] a,
                                    input logic [DATA_W-1:0] d);
    logic [31:0] ba;
    if (is_misaligned(op, a))
        return;                               // Dropped, memory untouched
    // Little endian, data byte i lands at address a + i
    for (int i = 0; i < access_size(op); i++)
    begin
        ba = a + i;
        ref_mem[word_index(ba)][(ba % 4) * 8 +: 8] = d[i*8 +: 8];
    end
endfunction

function automatic logic [DATA_W-1:0] expected_load(input mem_op_e op, input logic [31:0] a);
    logic [DATA_W-1:0] v;
    logic [31:0]       ba;
    int                n;
    n = access_size(op);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        ba = a + i;
        v[i*8 +: 8] = ref_mem[word_index(ba)][(ba % 4) * 8 +: 8];
    end
    // Signed kinds copy the top loaded bit upward
    if ((op == op_byte_s || op == op_half_s) && v[n*8-1])
    begin
        for (int i = n * 8; i < DATA_W; i++)
            v[i] = 1'b1;
    end
    return v;
endfunction

`endif

// ==== sim/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage
    import mem_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              mem_read;
    logic              mem_write;
    mem_op_e           mem_op;
    logic [31:0]       addr;
    logic [DATA_W-1:0] store_data;
    logic [DATA_W-1:0] load_data;
    logic              load_valid;
    logic              addr_error;

    typedef struct {
        int unsigned       due;               // Cycle the response must appear in
        bit                is_err;
        logic [DATA_W-1:0] data;
    } exp_rsp_t;

    exp_rsp_t    exp_q[$];
    int unsigned cycle_cnt;
    int          seed;
    int          check_cnt;
    int          err_cnt;
    int          test_err_base;

    `include "mem_ref_model.svh"

    initial clk = 1'b0;
    always #10 clk = ~clk;

    mem_stage u_dut (
        .clk        (clk),
        .reset      (reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_op     (mem_op),
        .addr       (addr),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .addr_error (addr_error)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] align_to(input mem_op_e op, input logic [31:0] a);
        return a - (a % access_size(op));
    endfunction

    task automatic log_mismatch(input string msg);
        err_cnt++;
        $display("ERR %0t ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    task automatic send_load(input mem_op_e op, input logic [31:0] a);
        @(posedge clk);
        mem_read  <= 1'b1;
        mem_write <= 1'b0;
        mem_op    <= op;
        addr      <= a;
    endtask

    task automatic send_store(input mem_op_e op, input logic [31:0] a,
                              input logic [DATA_W-1:0] d);
        @(posedge clk);
        mem_read   <= 1'b0;
        mem_write  <= 1'b1;
        mem_op     <= op;
        addr       <= a;
        store_data <= d;
    endtask

    ////////////////////////////////////////////////////////////
    // Response checker on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic check_response();
        exp_rsp_t e;
        if (load_valid || addr_error)
        begin
            check_cnt++;
            assert (exp_q.size() != 0)
            else
                report_failure($sformatf("Response at %0t ns with no request outstanding", $time));
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                assert (addr_error == e.is_err && load_valid == !e.is_err)
                else
                    log_mismatch($sformatf("load_valid=%b addr_error=%b, expected error=%b",
                                           load_valid, addr_error, e.is_err));
                if (!e.is_err)
                begin
                    assert (load_data === e.data)
                    else
                        log_mismatch($sformatf("load_data %h, expected %h", load_data, e.data));
                end
            end
        end
        else if (exp_q.size() != 0)
        begin
            assert (exp_q[0].due > cycle_cnt)
            else
            begin
                report_failure($sformatf("No response came for the request due in cycle %0d",
                                         exp_q[0].due));
                exp_q.delete(0);
            end
        end
    endtask

    // Model sees the request in the cycle it is on the DUT inputs
    task automatic capture_request();
        exp_rsp_t e;
        if (mem_read || mem_write)
        begin
            e.due    = cycle_cnt + 1;
            e.is_err = is_misaligned(mem_op, addr);
            e.data   = '0;
            if (mem_read && !e.is_err)
                e.data = expected_load(mem_op, addr);
            if (mem_read || e.is_err)
                exp_q.push_back(e);
            if (mem_write)
                apply_store(mem_op, addr, store_data);
        end
    endtask

    always @(negedge clk)
    begin
        cycle_cnt++;
        if (!reset)
        begin
            check_response();                 // Old responses first
            capture_request();
        end
    end

    task automatic end_test(input string name);
        int waited;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            report_failure($sformatf("Timed out waiting for %0d responses in %s",
                                     exp_q.size(), name));
            exp_q.delete();
        end
        $display("%s: %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0]       a;
        logic [DATA_W-1:0] d;
        mem_op_e           op;
        bit                last_store;
        logic [31:0]       last_addr;
        seed          = 7;
        cycle_cnt     = 0;
        check_cnt     = 0;
        err_cnt       = 0;
        test_err_base = 0;
        clear_model();
        reset      = 1'b1;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_op     = op_word;
        addr       = '0;
        store_data = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 32; i++)
            send_load(op_word, align_to(op_word, rand_word()));
        end_test("reset_zero");

        for (int i = 0; i < 24; i++)
        begin
            a = align_to(op_word, rand_word());
            send_store(op_word, a, rand_word());
            send_load(op_word, a);
            send_load(op_word, a + RAM_WORDS * 4 * ((rand_word() & 32'hff) + 1));  // Alias
        end
        end_test("word_alias");

        for (int i = 0; i < 8; i++)
        begin
            a = align_to(op_word, rand_word());
            send_store(op_word, a, rand_word());
            for (int lane = 0; lane < 4; lane++)
            begin
                send_store((lane % 2) ? op_byte_s : op_byte_u, a + lane, rand_word());
                send_load(op_word, a);
            end
            for (int lane = 0; lane < 4; lane += 2)
            begin
                send_store((lane == 0) ? op_half_u : op_half_s, a + lane, rand_word());
                send_load(op_word, a);
            end
        end
        end_test("lane_merge");

        a = align_to(op_word, rand_word());
        for (int i = 0; i < 6; i++)
        begin
            // Every lane with the top bit both set and clear
            d = (i == 0) ? 32'h807f_ff01 : (i == 1) ? 32'h7f80_01ff : rand_word();
            send_store(op_word, a, d);
            for (int off = 0; off < 4; off++)
            begin
                send_load(op_byte_u, a + off);
                send_load(op_byte_s, a + off);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                send_load(op_half_u, a + off);
                send_load(op_half_s, a + off);
            end
        end
        end_test("extend");

        for (int i = 0; i < 8; i++)
        begin
            a = align_to(op_word, rand_word());
            send_store(op_word, a, rand_word());
            for (int off = 1; off < 4; off++)
            begin
                send_store(op_word, a + off, rand_word());
                send_load(op_word, a + off);
            end
            send_store(op_half_u, a + 1, rand_word());
            send_store(op_half_s, a + 3, rand_word());
            send_load(op_half_s, a + 1);
            send_load(op_half_u, a + 3);
            send_load(op_word, a);            // Must still hold the first store
        end
        end_test("misaligned");

        last_store = 1'b0;
        last_addr  = '0;
        for (int i = 0; i < 2000; i++)
        begin
            op = mem_op_e'(rand_word() % 5);
            a  = rand_word() & 32'hffff_f03f;  // 16 words with random alias bits
            if ((rand_word() & 32'h1f) != 0)
                a = align_to(op, a);
            if (last_store && (rand_word() & 32'h3) == 0)
            begin
                send_load(op, align_to(op, last_addr));   // Read back the word just written
                last_store = 1'b0;
            end
            else if (rand_word() & 32'h1)
            begin
                send_store(op, a, rand_word());
                last_store = 1'b1;
                last_addr  = a;
            end
            else
            begin
                send_load(op, a);
                last_store = 1'b0;
            end
        end
        end_test("random_mix");

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_read,
    input  logic              mem_write,
    input  mem_op_e           mem_op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] store_data,
    output logic [DATA_W-1:0] load_data,
    output logic              load_valid,
    output logic              addr_error
);

    ////////////////////////////////////////////////////////////
    // Internal buses
    ////////////////////////////////////////////////////////////

    mem_req_if req_bus ();    // Request stage to RAM
    ram_rsp_if rsp_bus ();    // RAM to load extractor

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    // Combinational, same-cycle request
    store_align u_store_align (
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_op     (mem_op),
        .addr       (addr),
        .store_data (store_data),
        .req        (req_bus.req)
    );

    // Array plus one cycle of read latency
    data_ram u_data_ram (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.ram),
        .rsp   (rsp_bus.ram)
    );

    load_extract u_load_extract (
        .rsp        (rsp_bus.ext),
        .load_data  (load_data),
        .load_valid (load_valid),
        .addr_error (addr_error)
    );

endmodule

// ==== rtl/load_extract.sv ====
`timescale 1ns/1ps

module load_extract
    import mem_pkg::*;
(
    ram_rsp_if.ext            rsp,
    output logic [DATA_W-1:0] load_data,
    output logic              load_valid,
    output logic              addr_error
);

    logic [BYTE_W-1:0] byte_sel;
    logic [HALF_W-1:0] half_sel;
    logic              is_half;

    ////////////////////////////////////////////////////////////
    // Lane select
    ////////////////////////////////////////////////////////////

    assign byte_sel = rsp.rdata[rsp.byte_off*BYTE_W +: BYTE_W];
    assign half_sel = rsp.byte_off[1] ? rsp.rdata[DATA_W-1 -: HALF_W]
                                      : rsp.rdata[HALF_W-1:0];

    assign is_half = (rsp.op == op_half_u) || (rsp.op == op_half_s);

    ////////////////////////////////////////////////////////////
    // Extension
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (rsp.op)
            op_byte_u:
                load_data = {{(DATA_W - BYTE_W){1'b0}}, byte_sel};
            op_half_u:
                load_data = {{(DATA_W - HALF_W){1'b0}}, half_sel};
            op_byte_s:
                load_data = {{(DATA_W - BYTE_W){byte_sel[BYTE_W-1]}}, byte_sel};
            op_half_s:
                load_data = {{(DATA_W - HALF_W){half_sel[HALF_W-1]}}, half_sel};
            default:
                load_data = rsp.rdata;    // Full word
        endcase
    end

    // Flags pass straight through
    assign load_valid = rsp.rd_valid;
    assign addr_error = rsp.err_valid;

    // Odd halfwords are dropped upstream and never come back as data
    always_comb
    begin
        assert final (!(rsp.rd_valid && is_half && rsp.byte_off[0]))
            else $error("load_extract: halfword response at odd offset");
    end

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    mem_req_if.ram req,
    ram_rsp_if.ram rsp
);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // Reset wipes the whole array
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < RAM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (req.wr_en)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (req.byte_en[b])
                    mem[req.word_addr][b*BYTE_W +: BYTE_W] <= req.wdata[b*BYTE_W +: BYTE_W];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port and load context
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (req.rd_en)
        begin
            rsp.rdata    <= mem[req.word_addr];
            rsp.op       <= req.op;       // Kept for the extractor
            rsp.byte_off <= req.byte_off;
        end
    end

    // One-cycle response flags
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp.rd_valid  <= 1'b0;
            rsp.err_valid <= 1'b0;
        end
        else
        begin
            rsp.rd_valid  <= req.rd_en;
            rsp.err_valid <= req.misaligned;
        end
    end

    // Loads never carry byte enables
    assert property (@(posedge clk) disable iff (reset)
        (req.byte_en != '0) |-> req.wr_en)
        else $error("data_ram: byte_en set without wr_en");

    // A dropped access must not also return data
    assert property (@(posedge clk) disable iff (reset)
        !(rsp.rd_valid && rsp.err_valid))
        else $error("data_ram: rd_valid and err_valid together");

endmodule

// ==== rtl/store_align.sv ====
`timescale 1ns/1ps

module store_align
    import mem_pkg::*;
(
    input  logic              mem_read,
    input  logic              mem_write,
    input  mem_op_e           mem_op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] store_data,
    mem_req_if.req            req
);

    logic [OFF_W-1:0]  off;
    logic              access;
    logic              is_half;
    logic              is_word;
    logic              bad_align;
    logic              wr_ok;
    logic [BE_W-1:0]   lane_mask;
    logic [DATA_W-1:0] lane_data;

    assign off     = addr[OFF_W-1:0];
    assign access  = mem_read | mem_write;
    assign is_half = (mem_op == op_half_u) || (mem_op == op_half_s);
    assign is_word = (mem_op == op_word);

    ////////////////////////////////////////////////////////////
    // Alignment check
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        bad_align = 1'b0;
        if (is_half)
            bad_align = off[0];               // Odd halfword
        else if (is_word)
            bad_align = (off != '0);
    end

    ////////////////////////////////////////////////////////////
    // Byte enables and lane placement
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        lane_mask = '0;
        lane_data = store_data;
        case (mem_op)
            op_word:
            begin
                lane_mask = BE_ALL;
                lane_data = store_data;
            end
            op_half_u, op_half_s:
            begin
                lane_mask = off[1] ? BE_HALF_HI : BE_HALF_LO;
                // Same halfword on both halves, enables pick one
                lane_data = {(DATA_W / HALF_W){store_data[HALF_W-1:0]}};
            end
            default:                          // Byte kinds
            begin
                lane_mask = BE_W'(1) << off;
                lane_data = {BE_W{store_data[BYTE_W-1:0]}};
            end
        endcase
    end

    assign wr_ok = mem_write & ~bad_align;

    // Request out, dropped strobes on misalignment
    assign req.wr_en      = wr_ok;
    assign req.rd_en      = mem_read & ~bad_align;
    assign req.word_addr  = addr[OFF_W +: WORD_ADDR_W];    // Upper bits alias
    assign req.byte_en    = wr_ok ? lane_mask : '0;
    assign req.wdata      = lane_data;
    assign req.op         = mem_op;
    assign req.byte_off   = off;
    assign req.misaligned = access & bad_align;

    // Core never issues a load and a store together
    always_comb
    begin
        assert final (!(mem_read && mem_write))
            else $error("store_align: mem_read and mem_write both high");
    end

endmodule

// ==== rtl/ram_rsp_if.sv ====
`timescale 1ns/1ps

// Read word plus the load context it needs
interface ram_rsp_if
    import mem_pkg::*;
();

    logic [DATA_W-1:0] rdata;
    logic              rd_valid;
    mem_op_e           op;
    logic [OFF_W-1:0]  byte_off;
    logic              err_valid;   // Misaligned access seen last cycle

    modport ram (
        output rdata, rd_valid, op, byte_off, err_valid
    );

    modport ext (
        input rdata, rd_valid, op, byte_off, err_valid
    );

endinterface

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/1ps

// One aligned access, request stage to RAM
interface mem_req_if
    import mem_pkg::*;
();

    logic                   wr_en;
    logic                   rd_en;
    logic [WORD_ADDR_W-1:0] word_addr;
    logic [BE_W-1:0]        byte_en;
    logic [DATA_W-1:0]      wdata;       // Already on its lanes
    mem_op_e                op;
    logic [OFF_W-1:0]       byte_off;
    logic                   misaligned;

    modport req (
        output wr_en, rd_en, word_addr, byte_en, wdata, op, byte_off, misaligned
    );

    modport ram (
        input wr_en, rd_en, word_addr, byte_en, wdata, op, byte_off, misaligned
    );

endinterface

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_W      = 32;              // Data path width
    localparam int ADDR_W      = 32;              // Byte address
    localparam int RAM_WORDS   = 1024;
    localparam int WORD_ADDR_W = $clog2(RAM_WORDS);
    localparam int BE_W        = DATA_W / 8;      // Byte lanes per word

    // Lane helpers
    localparam int BYTE_W = 8;
    localparam int HALF_W = 16;
    localparam int OFF_W  = $clog2(BE_W);         // Byte offset inside a word

    // Byte enable patterns
    localparam logic [BE_W-1:0] BE_ALL     = {BE_W{1'b1}};
    localparam logic [BE_W-1:0] BE_HALF_LO = BE_W'(2'b11);
    localparam logic [BE_W-1:0] BE_HALF_HI = BE_HALF_LO << (BE_W / 2);

    ////////////////////////////////////////////////////////////
    // Access kinds
    ////////////////////////////////////////////////////////////

    // Stores ignore the signed/unsigned split
    typedef enum logic [2:0] {
        op_word   = 3'd0,
        op_byte_u = 3'd1,   // lbu / sb
        op_half_u = 3'd2,   // lhu / sh
        op_byte_s = 3'd3,   // lb
        op_half_s = 3'd4    // lh
    } mem_op_e;

endpackage
